// File: hw/rvPkg.sv
// RV32I instruction set definitions
// opcodes, funct codes and the instruction word in its five formats
package rvPkg;

	localparam int xlen = 32;

	// opcode groups handled by the core
	localparam logic [6:0] opRType = 7'b0110011;
	localparam logic [6:0] opIType = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;

	// funct3 values
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;
	localparam logic [2:0] f3Word = 3'b010;
	localparam logic [2:0] f3Beq = 3'b000;

	// funct7 values, bit 5 picks sub over add
	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Sub = 7'b0100000;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFmtT;

	typedef struct packed {
		logic [11:0] imm11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iFmtT;

	typedef struct packed {
		logic [6:0] imm11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4_0;
		logic [6:0] opcode;
	} sFmtT;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} bFmtT;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jFmtT;

	// one instruction word, several readings
	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
		sFmtT sFmt;
		bFmtT bFmt;
		jFmtT jFmt;
	} instrT;

endpackage

// File: hw/ctrlPkg.sv
// control encodings of the multicycle core
// controller states, mux selects, ALU operations and bridge states
package ctrlPkg;

	typedef enum logic [3:0] {
		stFetch = 4'd0,
		stDecode = 4'd1,
		stExecuteR = 4'd2,
		stExecuteI = 4'd3,
		stUncondJump = 4'd4,
		stMemAdr = 4'd5,
		stAluWb = 4'd6,
		stMemRead = 4'd7,
		stMemWrite = 4'd8,
		stMemWb = 4'd9,
		stBranchEq = 4'd10,
		stHalt = 4'd11
	} stateT;

	// ALU source A
	localparam logic [1:0] srcAPc = 2'd0;
	localparam logic [1:0] srcAOldPc = 2'd1;
	localparam logic [1:0] srcARegA = 2'd2;

	// ALU source B
	localparam logic [1:0] srcBReg = 2'd0;
	localparam logic [1:0] srcBImm = 2'd1;
	localparam logic [1:0] srcBFour = 2'd2;

	// result bus
	localparam logic [1:0] resAluOut = 2'd0;
	localparam logic [1:0] resMemData = 2'd1;
	localparam logic [1:0] resAluResult = 2'd2;

	// operation class from the controller
	localparam logic [1:0] aluOpAdd = 2'd0;
	localparam logic [1:0] aluOpSub = 2'd1;
	localparam logic [1:0] aluOpFunct = 2'd2;

	// immediate formats
	localparam logic [1:0] immI = 2'd0;
	localparam logic [1:0] immS = 2'd1;
	localparam logic [1:0] immB = 2'd2;
	localparam logic [1:0] immJ = 2'd3;

	// ALU operations
	localparam logic [2:0] aluAdd = 3'd0;
	localparam logic [2:0] aluSub = 3'd1;
	localparam logic [2:0] aluAnd = 3'd2;
	localparam logic [2:0] aluOr = 3'd3;
	localparam logic [2:0] aluSlt = 3'd5;

	// memory bridge states
	localparam logic [1:0] brIdle = 2'd0;
	localparam logic [1:0] brWaitHigh = 2'd1;
	localparam logic [1:0] brWaitLow = 2'd2;

endpackage

// File: hw/controlFsm.sv
`timescale 1ns/1ps
// multicycle control FSM, Moore outputs decoded from the current state
// waits on the memory bridge in fetch and in the data access states
module controlFsm (
	input logic clk,
	input logic reset,
	input rvPkg::instrT instr,
	input logic zero,
	input logic memDone,
	output logic memStart,
	output logic memWrite,
	output logic irWrite,
	output logic pcWrite,
	output logic regWrite,
	output logic adrSrc,
	output logic branch,
	output logic halted,
	output logic [1:0] srcASel,
	output logic [1:0] srcBSel,
	output logic [1:0] resultSel,
	output logic [1:0] aluOp,
	output logic [1:0] immSel
);

	ctrlPkg::stateT state;
	ctrlPkg::stateT nextState;
	logic [6:0] opcode;
	logic pcUpdate;

	assign opcode = instr.rFmt.opcode;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrlPkg::stFetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			ctrlPkg::stFetch: if (memDone) nextState = ctrlPkg::stDecode;
			ctrlPkg::stDecode: begin
				case (opcode)
					rvPkg::opRType: nextState = ctrlPkg::stExecuteR;
					rvPkg::opIType: nextState = ctrlPkg::stExecuteI;
					rvPkg::opLoad, rvPkg::opStore: nextState = ctrlPkg::stMemAdr;
					rvPkg::opBranch: nextState = ctrlPkg::stBranchEq;
					rvPkg::opJal: nextState = ctrlPkg::stUncondJump;
					default: nextState = ctrlPkg::stHalt;
				endcase
			end
			ctrlPkg::stExecuteR, ctrlPkg::stExecuteI: nextState = ctrlPkg::stAluWb;
			ctrlPkg::stUncondJump: nextState = ctrlPkg::stAluWb;
			ctrlPkg::stMemAdr: begin
				if (opcode == rvPkg::opLoad) begin
					nextState = ctrlPkg::stMemRead;
				end else if (opcode == rvPkg::opStore) begin
					nextState = ctrlPkg::stMemWrite;
				end else begin
					nextState = ctrlPkg::stHalt;
				end
			end
			ctrlPkg::stMemRead: if (memDone) nextState = ctrlPkg::stMemWb;
			ctrlPkg::stMemWrite: if (memDone) nextState = ctrlPkg::stFetch;
			ctrlPkg::stAluWb, ctrlPkg::stMemWb, ctrlPkg::stBranchEq: nextState = ctrlPkg::stFetch;
			ctrlPkg::stHalt: nextState = ctrlPkg::stHalt;
			default: nextState = ctrlPkg::stFetch;
		endcase
	end

	always_comb begin
		memStart = 1'b0;
		memWrite = 1'b0;
		irWrite = 1'b0;
		pcUpdate = 1'b0;
		regWrite = 1'b0;
		adrSrc = 1'b0;
		branch = 1'b0;
		halted = 1'b0;
		srcASel = ctrlPkg::srcAPc;
		srcBSel = ctrlPkg::srcBFour;
		resultSel = ctrlPkg::resAluResult;
		aluOp = ctrlPkg::aluOpAdd;
		case (state)
			ctrlPkg::stFetch: begin
				// pc+4 and the new word land together once the read completes
				memStart = 1'b1;
				irWrite = memDone;
				pcUpdate = memDone;
			end
			ctrlPkg::stDecode: begin
				// branch or jump target into aluOut
				srcASel = ctrlPkg::srcAOldPc;
				srcBSel = ctrlPkg::srcBImm;
			end
			ctrlPkg::stExecuteR: begin
				srcASel = ctrlPkg::srcARegA;
				srcBSel = ctrlPkg::srcBReg;
				aluOp = ctrlPkg::aluOpFunct;
			end
			ctrlPkg::stExecuteI: begin
				srcASel = ctrlPkg::srcARegA;
				srcBSel = ctrlPkg::srcBImm;
				aluOp = ctrlPkg::aluOpFunct;
			end
			ctrlPkg::stUncondJump: begin
				// link value oldPc+4 while pc takes the target
				srcASel = ctrlPkg::srcAOldPc;
				resultSel = ctrlPkg::resAluOut;
				pcUpdate = 1'b1;
			end
			ctrlPkg::stMemAdr: begin
				srcASel = ctrlPkg::srcARegA;
				srcBSel = ctrlPkg::srcBImm;
			end
			ctrlPkg::stMemRead, ctrlPkg::stMemWrite: begin
				// same address sum keeps aluOut steady for the whole access
				srcASel = ctrlPkg::srcARegA;
				srcBSel = ctrlPkg::srcBImm;
				resultSel = ctrlPkg::resAluOut;
				adrSrc = 1'b1;
				memStart = 1'b1;
				memWrite = (state == ctrlPkg::stMemWrite);
			end
			ctrlPkg::stAluWb: begin
				resultSel = ctrlPkg::resAluOut;
				regWrite = 1'b1;
			end
			ctrlPkg::stMemWb: begin
				resultSel = ctrlPkg::resMemData;
				regWrite = 1'b1;
			end
			ctrlPkg::stBranchEq: begin
				srcASel = ctrlPkg::srcARegA;
				srcBSel = ctrlPkg::srcBReg;
				aluOp = ctrlPkg::aluOpSub;
				resultSel = ctrlPkg::resAluOut;
				branch = 1'b1;
			end
			ctrlPkg::stHalt: halted = 1'b1;
			default: halted = 1'b0;
		endcase
	end

	// immediate format follows the opcode held in ir
	always_comb begin
		case (opcode)
			rvPkg::opStore: immSel = ctrlPkg::immS;
			rvPkg::opBranch: immSel = ctrlPkg::immB;
			rvPkg::opJal: immSel = ctrlPkg::immJ;
			default: immSel = ctrlPkg::immI;
		endcase
	end

	assign pcWrite = pcUpdate | (branch & zero);

endmodule

// File: hw/aluUnit.sv
`timescale 1ns/1ps
// ALU decoder and ALU
// maps the operation class and funct fields to an operation, flags a zero result
module aluUnit (
	input logic [1:0] aluOp,
	input rvPkg::instrT instr,
	input logic [rvPkg::xlen-1:0] a,
	input logic [rvPkg::xlen-1:0] b,
	output logic [rvPkg::xlen-1:0] result,
	output logic zero
);

	logic [2:0] aluCtl;
	logic isSub;

	// addi carries immediate bits in the funct7 slot, so only the R form can subtract
	assign isSub = (instr.rFmt.opcode == rvPkg::opRType) && (instr.rFmt.funct7 == rvPkg::f7Sub);

	always_comb begin
		case (aluOp)
			ctrlPkg::aluOpAdd: aluCtl = ctrlPkg::aluAdd;
			ctrlPkg::aluOpSub: aluCtl = ctrlPkg::aluSub;
			ctrlPkg::aluOpFunct: begin
				case (instr.rFmt.funct3)
					rvPkg::f3AddSub: aluCtl = isSub ? ctrlPkg::aluSub : ctrlPkg::aluAdd;
					rvPkg::f3Slt: aluCtl = ctrlPkg::aluSlt;
					rvPkg::f3Or: aluCtl = ctrlPkg::aluOr;
					rvPkg::f3And: aluCtl = ctrlPkg::aluAnd;
					default: aluCtl = ctrlPkg::aluAdd;
				endcase
			end
			default: aluCtl = ctrlPkg::aluAdd;
		endcase
	end

	always_comb begin
		case (aluCtl)
			ctrlPkg::aluAdd: result = a + b;
			ctrlPkg::aluSub: result = a - b;
			ctrlPkg::aluAnd: result = a & b;
			ctrlPkg::aluOr: result = a | b;
			ctrlPkg::aluSlt: begin
				// signed compare
				result = {{(rvPkg::xlen - 1){1'b0}}, $signed(a) < $signed(b)};
			end
			default: result = a + b;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps
// 32-entry register file, two read ports and one write port, x0 reads zero
module regFile (
	input logic clk,
	input logic reset,
	input logic we,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] rd,
	input logic [rvPkg::xlen-1:0] wd,
	output logic [rvPkg::xlen-1:0] rd1,
	output logic [rvPkg::xlen-1:0] rd2
);

	logic [rvPkg::xlen-1:0] regs [0:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (we && (rd != 5'd0)) begin
			regs[rd] <= wd;
		end
	end

	// x0 hardwired
	assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: hw/immExtend.sv
`timescale 1ns/1ps
// immediate unit, sign-extends the I, S, B and J immediates
module immExtend (
	input rvPkg::instrT instr,
	input logic [1:0] immSel,
	output logic [rvPkg::xlen-1:0] imm
);

	always_comb begin
		case (immSel)
			ctrlPkg::immI: imm = {{20{instr.iFmt.imm11_0[11]}}, instr.iFmt.imm11_0};
			ctrlPkg::immS: begin
				imm = {{20{instr.sFmt.imm11_5[6]}}, instr.sFmt.imm11_5, instr.sFmt.imm4_0};
			end
			ctrlPkg::immB: begin
				// bit 0 is always zero for branch offsets
				imm = {{19{instr.bFmt.imm12}}, instr.bFmt.imm12, instr.bFmt.imm11,
					instr.bFmt.imm10_5, instr.bFmt.imm4_1, 1'b0};
			end
			ctrlPkg::immJ: begin
				imm = {{11{instr.jFmt.imm20}}, instr.jFmt.imm20, instr.jFmt.imm19_12,
					instr.jFmt.imm11, instr.jFmt.imm10_1, 1'b0};
			end
		endcase
	end

endmodule

// File: hw/memBridge.sv
`timescale 1ns/1ps
// four-phase req/ack bridge between the controller and the memory port
module memBridge (
	input logic clk,
	input logic reset,
	input logic start,
	input logic memAck,
	output logic memReq,
	output logic capture,
	output logic memDone
);

	logic [1:0] state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrlPkg::brIdle;
		end else begin
			case (state)
				ctrlPkg::brIdle: begin
					// previous handshake must be fully closed first
					if (start && !memAck) state <= ctrlPkg::brWaitHigh;
				end
				ctrlPkg::brWaitHigh: if (memAck) state <= ctrlPkg::brWaitLow;
				ctrlPkg::brWaitLow: if (!memAck) state <= ctrlPkg::brIdle;
				default: state <= ctrlPkg::brIdle;
			endcase
		end
	end

	assign memReq = (state == ctrlPkg::brWaitHigh);

	// read data is only valid while ack is high
	assign capture = memReq && memAck;

	// done once ack has fallen, controller leaves its wait state on this edge
	assign memDone = (state == ctrlPkg::brWaitLow) && !memAck;

endmodule

// File: hw/rvCore.sv
`timescale 1ns/1ps
// multicycle RV32I core, datapath registers and muxes around the controller
// one four-phase memory port serves both fetch and data
module rvCore (
	input logic clk,
	input logic reset,
	output logic memReq,
	output logic memWe,
	output logic [rvPkg::xlen-1:0] memAddr,
	output logic [rvPkg::xlen-1:0] memWdata,
	input logic [rvPkg::xlen-1:0] memRdata,
	input logic memAck,
	output logic halted
);

	logic [rvPkg::xlen-1:0] pc;
	logic [rvPkg::xlen-1:0] oldPc;
	logic [rvPkg::xlen-1:0] memData;
	logic [rvPkg::xlen-1:0] regA;
	logic [rvPkg::xlen-1:0] regB;
	logic [rvPkg::xlen-1:0] aluOut;
	rvPkg::instrT ir;

	logic [rvPkg::xlen-1:0] srcA;
	logic [rvPkg::xlen-1:0] srcB;
	logic [rvPkg::xlen-1:0] aluResult;
	logic [rvPkg::xlen-1:0] result;
	logic [rvPkg::xlen-1:0] imm;
	logic [rvPkg::xlen-1:0] rd1;
	logic [rvPkg::xlen-1:0] rd2;

	logic pcWrite, irWrite, regWrite, adrSrc, zero;
	logic memStart, memDone, capture;
	logic [1:0] srcASel, srcBSel, resultSel, aluOp, immSel;

	// branch is folded into pcWrite inside the controller
	controlFsm uCtrl (
		.clk(clk),
		.reset(reset),
		.instr(ir),
		.zero(zero),
		.memDone(memDone),
		.memStart(memStart),
		.memWrite(memWe),
		.irWrite(irWrite),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.adrSrc(adrSrc),
		.branch(),
		.halted(halted),
		.srcASel(srcASel),
		.srcBSel(srcBSel),
		.resultSel(resultSel),
		.aluOp(aluOp),
		.immSel(immSel)
	);

	memBridge uBridge (
		.clk(clk),
		.reset(reset),
		.start(memStart),
		.memAck(memAck),
		.memReq(memReq),
		.capture(capture),
		.memDone(memDone)
	);

	regFile uRegs (
		.clk(clk),
		.reset(reset),
		.we(regWrite),
		.rs1(ir.rFmt.rs1),
		.rs2(ir.rFmt.rs2),
		.rd(ir.rFmt.rd),
		.wd(result),
		.rd1(rd1),
		.rd2(rd2)
	);

	immExtend uImm (
		.instr(ir),
		.immSel(immSel),
		.imm(imm)
	);

	aluUnit uAlu (
		.aluOp(aluOp),
		.instr(ir),
		.a(srcA),
		.b(srcB),
		.result(aluResult),
		.zero(zero)
	);

	always_comb begin
		case (srcASel)
			ctrlPkg::srcAOldPc: srcA = oldPc;
			ctrlPkg::srcARegA: srcA = regA;
			default: srcA = pc;
		endcase
	end

	always_comb begin
		case (srcBSel)
			ctrlPkg::srcBReg: srcB = regB;
			ctrlPkg::srcBImm: srcB = imm;
			default: srcB = 32'd4;
		endcase
	end

	always_comb begin
		case (resultSel)
			ctrlPkg::resAluOut: result = aluOut;
			ctrlPkg::resMemData: result = memData;
			default: result = aluResult;
		endcase
	end

	// data accesses use the address held in aluOut
	assign memAddr = adrSrc ? result : pc;
	assign memWdata = regB;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (pcWrite) begin
			pc <= result;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) memData <= memRdata;
		// memData already holds the fetched word when fetch completes
		if (irWrite) begin
			ir <= memData;
			oldPc <= pc;
		end
		regA <= rd1;
		regB <= rd2;
		aluOut <= aluResult;
	end

endmodule

// File: tests/rvCore_sva.sv
`timescale 1ns/1ps
// four-phase handshake checks on the core memory port
module rvCoreSva (
	input logic clk,
	input logic reset,
	input logic memReq,
	input logic memAck,
	input logic memWe
);

	int failures = 0;

	// request held until the memory answers
	reqHeld: assert property (@(posedge clk) disable iff (reset)
		memReq && !memAck |=> memReq)
	else begin
		failures++;
		$error("memReq dropped before memAck");
	end

	// new request only once the previous ack is gone
	reqRiseAckLow: assert property (@(posedge clk) disable iff (reset)
		$rose(memReq) |-> !memAck)
	else begin
		failures++;
		$error("memReq rose while memAck was high");
	end

	weStable: assert property (@(posedge clk) disable iff (reset)
		memReq && !memAck |=> $stable(memWe))
	else begin
		failures++;
		$error("memWe changed during a request");
	end

endmodule

bind rvCore rvCoreSva handshakeChecks (
	.clk(clk),
	.reset(reset),
	.memReq(memReq),
	.memAck(memAck),
	.memWe(memWe)
);

// File: tests/rvCoreTb.sv
`timescale 1ns/1ps
// testbench for the multicycle RV32I core
// random programs run against an ISA model behind a four-phase memory with random ack delays
module rvCoreTb;

	localparam int clkPeriod = 4;
	localparam int resetCycles = 16;
	localparam int numTests = 5;
	localparam int bodyLen = 48;
	localparam int progWords = bodyLen + 33;
	localparam int midRunCycles = 200;
	localparam int quietCycles = 20;
	localparam int maxSteps = 2000;
	// final register dump and random data accesses use separate word ranges
	localparam int dumpBase = 768;
	localparam int loadBase = 896;
	localparam int cyclesPerInstr = 40;
	localparam int watchdogCycles = cyclesPerInstr * progWords * numTests
		+ numTests * (2 * resetCycles + quietCycles) + midRunCycles;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic memReq;
	logic memWe;
	logic [31:0] memAddr;
	logic [31:0] memWdata;
	logic [31:0] memRdata = '0;
	logic memAck = 1'b0;
	logic halted;

	int seed = 32'h5c8cc0d1;
	int errors = 0;
	int testsPassed = 0;
	int holdCnt = 0;

	logic [31:0] prog [0:255];
	logic [31:0] dutMem [0:255];
	logic [31:0] modelMem [0:255];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] wantAddr;
	logic [31:0] wantData;

	rvCore dut_i (
		.clk(clk),
		.reset(reset),
		.memReq(memReq),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memRdata(memRdata),
		.memAck(memAck),
		.halted(halted)
	);

	initial begin
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("watchdog expired at %0t, the core did not halt in time", $time);
		$display("Testbench failed");
		$finish;
	end

	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	function automatic logic [4:0] randReg();
		// a small register set keeps the dependency chains short
		return 5'(randBelow(8));
	endfunction

	function automatic logic [31:0] fillWord(input int i);
		return 32'h9e3779b9 * 32'(i + 1);
	endfunction

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		rvPkg::instrT w;
		w.rFmt.funct7 = f7;
		w.rFmt.rs2 = rs2;
		w.rFmt.rs1 = rs1;
		w.rFmt.funct3 = f3;
		w.rFmt.rd = rd;
		w.rFmt.opcode = rvPkg::opRType;
		return w;
	endfunction

	function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		rvPkg::instrT w;
		w.iFmt.imm11_0 = imm;
		w.iFmt.rs1 = rs1;
		w.iFmt.funct3 = f3;
		w.iFmt.rd = rd;
		w.iFmt.opcode = op;
		return w;
	endfunction

	function automatic logic [31:0] encS(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		rvPkg::instrT w;
		w.sFmt.imm11_5 = imm[11:5];
		w.sFmt.rs2 = rs2;
		w.sFmt.rs1 = rs1;
		w.sFmt.funct3 = rvPkg::f3Word;
		w.sFmt.imm4_0 = imm[4:0];
		w.sFmt.opcode = rvPkg::opStore;
		return w;
	endfunction

	function automatic logic [31:0] encB(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] off);
		rvPkg::instrT w;
		w.bFmt.imm12 = off[12];
		w.bFmt.imm10_5 = off[10:5];
		w.bFmt.rs2 = rs2;
		w.bFmt.rs1 = rs1;
		w.bFmt.funct3 = rvPkg::f3Beq;
		w.bFmt.imm4_1 = off[4:1];
		w.bFmt.imm11 = off[11];
		w.bFmt.opcode = rvPkg::opBranch;
		return w;
	endfunction

	function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
		rvPkg::instrT w;
		w.jFmt.imm20 = off[20];
		w.jFmt.imm10_1 = off[10:1];
		w.jFmt.imm11 = off[11];
		w.jFmt.imm19_12 = off[19:12];
		w.jFmt.rd = rd;
		w.jFmt.opcode = rvPkg::opJal;
		return w;
	endfunction

	function automatic logic [2:0] randFunct3();
		case (randBelow(4))
			0: return rvPkg::f3AddSub;
			1: return rvPkg::f3Slt;
			2: return rvPkg::f3Or;
			default: return rvPkg::f3And;
		endcase
	endfunction

	// random body, then a store of every register and an illegal opcode
	task automatic genProgram();
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [11:0] imm;
		logic [2:0] f3;
		logic [6:0] f7;
		for (int i = 0; i < bodyLen; i++) begin
			rd = randReg();
			rs1 = randReg();
			rs2 = randReg();
			imm = 12'(randBelow(4096));
			f3 = randFunct3();
			f7 = (f3 == rvPkg::f3AddSub && randBelow(2) == 0) ? rvPkg::f7Sub : rvPkg::f7Base;
			case (randBelow(8))
				0, 1: prog[i] = encR(f7, rs2, rs1, f3, rd);
				2, 3: prog[i] = encI(rvPkg::opIType, f3, rd, rs1, imm);
				4: prog[i] = encI(rvPkg::opLoad, rvPkg::f3Word, rd, 5'd0,
					12'(loadBase + 4 * randBelow(32)));
				5: prog[i] = encS(rs2, 5'd0, 12'(loadBase + 4 * randBelow(32)));
				6: begin
					// equal operands half the time so beq is taken often
					if (randBelow(2) == 0) rs2 = rs1;
					prog[i] = encB(rs1, rs2, 13'(4 * (1 + randBelow(3))));
				end
				default: prog[i] = encJ(rd, 21'(4 * (1 + randBelow(3))));
			endcase
		end
		for (int k = 0; k < 32; k++) begin
			prog[bodyLen + k] = encS(5'(k), 5'd0, 12'(dumpBase + 4 * k));
		end
		prog[bodyLen + 32] = 32'h0000007f;
	endtask

	task automatic loadMemories();
		for (int i = 0; i < 256; i++) begin
			dutMem[i] = (i < progWords) ? prog[i] : fillWord(i);
			modelMem[i] = dutMem[i];
		end
	endtask

	// ISA reference, fills the expected store sequence and the final image
	task automatic runModel();
		logic [31:0] xr [0:31];
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] val;
		logic [31:0] addr;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [4:0] rd;
		bit wr;
		bit running;
		int steps;
		for (int k = 0; k < 32; k++) begin
			xr[k] = '0;
		end
		expAddr.delete();
		expData.delete();
		pc = '0;
		running = 1'b1;
		steps = 0;
		while (running && steps < maxSteps) begin
			ins = modelMem[pc[9:2]];
			rd = ins[11:7];
			a = xr[ins[19:15]];
			b = xr[ins[24:20]];
			immI = {{20{ins[31]}}, ins[31:20]};
			immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			nextPc = pc + 32'd4;
			val = '0;
			wr = 1'b0;
			case (ins[6:0])
				rvPkg::opRType, rvPkg::opIType: begin
					if (ins[6:0] == rvPkg::opIType) b = immI;
					case (ins[14:12])
						3'b000: begin
							// only the register form can subtract
							if (ins[6:0] == rvPkg::opRType && ins[31:25] == 7'b0100000) begin
								val = a - b;
							end else begin
								val = a + b;
							end
						end
						3'b010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						3'b110: val = a | b;
						default: val = a & b;
					endcase
					wr = 1'b1;
				end
				rvPkg::opLoad: begin
					addr = a + immI;
					val = modelMem[addr[9:2]];
					wr = 1'b1;
				end
				rvPkg::opStore: begin
					addr = a + immS;
					modelMem[addr[9:2]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
				end
				rvPkg::opBranch: if (a == b) nextPc = pc + immB;
				rvPkg::opJal: begin
					val = pc + 32'd4;
					wr = 1'b1;
					nextPc = pc + immJ;
				end
				default: running = 1'b0;
			endcase
			if (wr && rd != 5'd0) xr[rd] = val;
			pc = nextPc;
			steps++;
		end
	endtask

	// four-phase memory, 0 to 5 cycles before each ack edge
	always @(posedge clk) begin
		if (reset) begin
			memAck <= 1'b0;
			holdCnt = 0;
		end else if (!memAck && memReq) begin
			if (holdCnt > 0) begin
				holdCnt = holdCnt - 1;
			end else begin
				memAck <= 1'b1;
				holdCnt = randBelow(6);
				if (memWe) begin
					if (expAddr.size() == 0) begin
						$display("store to %h at %0t with no store left in the model sequence",
							memAddr, $time);
						errors++;
					end else begin
						wantAddr = expAddr.pop_front();
						wantData = expData.pop_front();
						if (memAddr != wantAddr || memWdata != wantData) begin
							$display("MISMATCH at %0t: store %h <- %h, model expects %h <- %h",
								$time, memAddr, memWdata, wantAddr, wantData);
							errors++;
						end
					end
					dutMem[memAddr[9:2]] = memWdata;
				end else begin
					memRdata <= dutMem[memAddr[9:2]];
				end
			end
		end else if (memAck && !memReq) begin
			if (holdCnt > 0) begin
				holdCnt = holdCnt - 1;
			end else begin
				memAck <= 1'b0;
				holdCnt = randBelow(6);
			end
		end
	end

	task automatic applyReset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic checkFirstFetch();
		do @(posedge clk); while (!memReq);
		if (memWe || memAddr != 32'd0) begin
			$display("MISMATCH at %0t: first request after reset is we=%0b addr %h, expected a read of 0",
				$time, memWe, memAddr);
			errors++;
		end
	endtask

	task automatic runTest(input int idx, input bit midReset);
		int errBefore;
		errBefore = errors;
		genProgram();
		loadMemories();
		runModel();
		applyReset();
		if (midReset) begin
			repeat (midRunCycles) @(posedge clk);
			reset <= 1'b1;
			@(posedge clk);
			// restart from a fresh image, stores already seen matched the same sequence
			loadMemories();
			runModel();
			repeat (resetCycles - 1) @(posedge clk);
			reset <= 1'b0;
			checkFirstFetch();
		end
		while (!halted) @(posedge clk);
		repeat (quietCycles) begin
			@(posedge clk);
			if (memReq) begin
				$display("memReq raised at %0t while the core is halted", $time);
				errors++;
			end
		end
		if (expAddr.size() != 0) begin
			$display("%0d expected stores never reached memory", expAddr.size());
			errors++;
		end
		for (int i = 0; i < 256; i++) begin
			if (dutMem[i] != modelMem[i]) begin
				$display("MISMATCH at %0t: memory word %0d is %h, model has %h",
					$time, i, dutMem[i], modelMem[i]);
				errors++;
			end
		end
		if (errors == errBefore) testsPassed++;
		$display("test %0d (%s): %s, %0d errors", idx, midReset ? "reset mid-run" : "random program",
			(errors == errBefore) ? "ok" : "FAILED", errors - errBefore);
	endtask

	initial begin
		for (int t = 0; t < numTests; t++) begin
			runTest(t, t == numTests - 1);
		end
		errors = errors + dut_i.handshakeChecks.failures;
		$display("%0d tests run, %0d passed, %0d failed, %0d errors in total",
			numTests, testsPassed, numTests - testsPassed, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: all.f
hw/rvPkg.sv
hw/ctrlPkg.sv
hw/controlFsm.sv
hw/aluUnit.sv
hw/regFile.sv
hw/immExtend.sv
hw/memBridge.sv
hw/rvCore.sv
tests/rvCore_sva.sv
tests/rvCoreTb.sv

// File: Makefile
# Verilator flow for the multicycle RV32I core

VERILATOR ?= verilator
TOP ?= rvCoreTb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
